// ==== rtl/cpu_bus_pkg.sv ====
// cpu bus shared by both register banks, one request per clock and no handshake
// addr is a 16-bit word address, dsn holds active-low byte strobes
`default_nettype none

package cpu_bus_pkg;

    // word address width, 32 register slots per chip select
    localparam int ADDR_W = 5;

    // active-low byte strobe patterns
    localparam logic [1:0] DSN_FULL = 2'b00;
    localparam logic [1:0] DSN_NONE = 2'b11;

    // all-ones word address
    // reads back FFFF, and as a slot address it turns mult and prio slots off
    localparam logic [ADDR_W-1:0] ADDR_NONE = '1;

    // one bus cycle
    typedef struct packed {
        // fixed bank select
        logic              ppu1_cs;
        // programmable bank select
        logic              ppu2_cs;
        logic [ADDR_W-1:0] addr;
        logic [1:0]        dsn;
        logic [15:0]       wdata;
    } cpu_req_t;

endpackage

`default_nettype wire

// ==== rtl/video_regs_pkg.sv ====
// register contents of the two video chips and the layout of the config string
// slot addresses share their width with the cpu bus word address
`default_nettype none

package video_regs_pkg;

    // length of the programmable-map configuration string
    localparam int CFG_BYTES = 24;

    // layer order 0,1,2,3 from the top, no layer disabled
    localparam logic [15:0] LAYER_CTRL_RST = {3'd0, 2'b11, 2'b10, 2'b01, 2'b00, 5'd0};
    // copy all palette pages
    localparam logic [5:0]  PAL_PAGE_RST   = 6'h3f;

    // fields decoded from the configuration string
    typedef struct packed {
        // word addresses of the programmable slots
        logic [cpu_bus_pkg::ADDR_W-1:0] id, mult1, mult2, rslt0, rslt1, layer;
        logic [cpu_bus_pkg::ADDR_W-1:0] prio0, prio1, prio2, prio3;
        logic [cpu_bus_pkg::ADDR_W-1:0] in2, in3, pal_page;
        // 16-bit id packed as two nibbles
        logic [7:0]  cpsb_id;
        // layer 4 uses layer_mask3 downstream
        logic [7:0]  layer_mask0, layer_mask1, layer_mask2, layer_mask3;
        // rom mapper
        logic [5:0]  game;
        logic [15:0] bank_offset;
        logic [15:0] bank_mask;
        // 0 for 10 MHz, 1 for 12 MHz
        logic        cpu_speed;
        logic        six_button;
        logic        charger;
        logic        kabuki_en;
    } cfg_map_t;

    typedef struct packed {
        logic [15:0] hpos1, hpos2, hpos3;
        logic [15:0] vpos1, vpos2, vpos3;
        logic [15:0] hstar1, hstar2, vstar1, vstar2;
    } scroll_regs_t;

    typedef struct packed {
        logic [15:0] vram1_base, vram2_base, vram3_base;
        logic [15:0] vram_obj_base, vram_row_base, row_offset;
        logic [15:0] pal_base, ppu_ctrl;
    } base_regs_t;

    // mixer controls held in the programmable bank
    typedef struct packed {
        logic [15:0] layer_ctrl;
        logic [15:0] prio0, prio1, prio2, prio3;
        logic [5:0]  pal_page_en;
    } mix_regs_t;

    // player inputs read through the programmable bank
    typedef struct packed {
        logic [3:0] start;
        logic [3:0] coin;
        logic [9:0] joy1, joy2, joy3, joy4;
    } player_in_t;

endpackage

`default_nettype wire

// ==== rtl/cfg_map_loader.sv ====
// configuration string loader, one byte per rising edge of cfg_we
// the string itself has no reset and must be sent in full after power-up
`timescale 1ns/1ps
`default_nettype none

module cfg_map_loader (
    input  wire logic                   clk,
    input  wire logic                   reg_rst,
    input  wire logic                   cfg_we,
    input  wire logic [7:0]             cfg_data,
    output video_regs_pkg::cfg_map_t    map
);

    // byte n of the string is cfg_str[n]
    logic [video_regs_pkg::CFG_BYTES-1:0][7:0] cfg_str;
    logic last_cfg_we;
    logic cfg_edge;

    // cfg_we may come from a slower clock domain, so only its edge counts
    always_ff @(posedge clk, posedge reg_rst) begin
        if (reg_rst) begin
            last_cfg_we <= 1'b0;
        end else begin
            last_cfg_we <= cfg_we;
        end
    end

    assign cfg_edge = cfg_we && !last_cfg_we;

    // new byte enters at the top, first byte sent lands in byte 0
    always_ff @(posedge clk) begin
        if (cfg_edge) begin
            cfg_str <= {cfg_data, cfg_str[video_regs_pkg::CFG_BYTES-1:1]};
        end
    end

    always_comb begin
        // slot addresses are stored as byte offsets
        map.id          = cfg_str[0][5:1];
        map.cpsb_id     = cfg_str[1];
        map.mult1       = cfg_str[2][5:1];
        map.mult2       = cfg_str[3][5:1];
        map.rslt0       = cfg_str[4][5:1];
        map.rslt1       = cfg_str[5][5:1];
        map.layer       = cfg_str[6][5:1];
        map.prio0       = cfg_str[7][5:1];
        map.prio1       = cfg_str[8][5:1];
        map.prio2       = cfg_str[9][5:1];
        map.prio3       = cfg_str[10][5:1];
        map.in2         = cfg_str[11][5:1];
        map.in3         = cfg_str[12][5:1];
        map.pal_page    = cfg_str[13][5:1];
        map.layer_mask0 = cfg_str[14];
        map.layer_mask1 = cfg_str[15];
        map.layer_mask2 = cfg_str[16];
        map.layer_mask3 = cfg_str[17];
        // mapper, low byte first
        map.game        = cfg_str[18][5:0];
        map.bank_offset = {cfg_str[20], cfg_str[19]};
        map.bank_mask   = {cfg_str[22], cfg_str[21]};
        // flag byte, bits 2:1 and 7:6 unused
        map.cpu_speed   = cfg_str[23][0];
        map.six_button  = cfg_str[23][3];
        map.charger     = cfg_str[23][4];
        map.kabuki_en   = cfg_str[23][5];
    end

endmodule

`default_nettype wire

// ==== rtl/fixed_reg_bank.sv ====
// fixed-address bank, only full 16-bit writes land
// pal_copy and obj_dma_ok wait for a pixel clock with the bus idle
`timescale 1ns/1ps
`default_nettype none

module fixed_reg_bank (
    input  wire logic                       clk,
    input  wire logic                       reg_rst,
    input  wire logic                       pxl_cen,
    input  cpu_bus_pkg::cpu_req_t           cpu,
    output video_regs_pkg::scroll_regs_t    scroll,
    output video_regs_pkg::base_regs_t      bases,
    output logic                            pal_copy,
    output logic                            obj_dma_ok
);

    logic full_wr;
    logic xfer;
    // writes seen but not yet passed to the strobes
    logic pend_copy;
    logic pend_dma;

    assign full_wr = cpu.ppu1_cs && (cpu.dsn == cpu_bus_pkg::DSN_FULL);
    // base values settle only once the select has dropped
    assign xfer    = pxl_cen && !cpu.ppu1_cs;

    always_ff @(posedge clk, posedge reg_rst) begin
        if (reg_rst) begin
            scroll     <= '0;
            bases      <= '0;
            pend_copy  <= 1'b0;
            pend_dma   <= 1'b0;
            pal_copy   <= 1'b0;
            obj_dma_ok <= 1'b0;
        end else begin
            // strobes hold until the next idle pixel clock
            if (xfer) begin
                pal_copy   <= pend_copy;
                pend_copy  <= 1'b0;
                obj_dma_ok <= pend_dma;
                pend_dma   <= 1'b0;
            end
            // xfer needs ppu1_cs low, so it never meets a write here
            if (full_wr) begin
                case (cpu.addr)
                    5'h00: begin
                        bases.vram_obj_base <= cpu.wdata;
                        pend_dma            <= 1'b1;
                    end
                    5'h01: bases.vram1_base    <= cpu.wdata;
                    5'h02: bases.vram2_base    <= cpu.wdata;
                    5'h03: bases.vram3_base    <= cpu.wdata;
                    5'h04: bases.vram_row_base <= cpu.wdata;
                    5'h05: begin
                        bases.pal_base <= cpu.wdata;
                        pend_copy      <= 1'b1;
                    end
                    // scroll positions
                    5'h06: scroll.hpos1  <= cpu.wdata;
                    5'h07: scroll.vpos1  <= cpu.wdata;
                    5'h08: scroll.hpos2  <= cpu.wdata;
                    5'h09: scroll.vpos2  <= cpu.wdata;
                    5'h0a: scroll.hpos3  <= cpu.wdata;
                    5'h0b: scroll.vpos3  <= cpu.wdata;
                    // star field
                    5'h0c: scroll.hstar1 <= cpu.wdata;
                    5'h0d: scroll.vstar1 <= cpu.wdata;
                    5'h0e: scroll.hstar2 <= cpu.wdata;
                    5'h0f: scroll.vstar2 <= cpu.wdata;
                    5'h10: bases.row_offset <= cpu.wdata;
                    5'h11: bases.ppu_ctrl   <= cpu.wdata;
                    // words 12 to 1f are not decoded
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/prog_reg_bank.sv ====
// programmable-map bank, slot addresses come from the configuration string
// any active byte strobe writes the whole word; reads land in mmr_dout next clock
`timescale 1ns/1ps
`default_nettype none

module prog_reg_bank #(
    // register stages after the multiplier, 1 or 2
    parameter int MULT_LATENCY = 1
) (
    input  wire logic                       clk,
    input  wire logic                       reg_rst,
    input  cpu_bus_pkg::cpu_req_t           cpu,
    input  video_regs_pkg::cfg_map_t        map,
    input  video_regs_pkg::player_in_t      players,
    output video_regs_pkg::mix_regs_t       mix,
    output logic [15:0]                     mmr_dout
);

    logic hit_id, hit_mult1, hit_mult2, hit_rslt0, hit_rslt1, hit_layer;
    logic hit_prio0, hit_prio1, hit_prio2, hit_prio3, hit_pal, hit_in2, hit_in3;
    logic        wr;
    logic [15:0] mult1, mult2;
    logic [31:0] prod_pipe [0:MULT_LATENCY-1];
    logic [31:0] rslt;
    logic [7:0]  in2, in3;
    logic [15:0] rd_val;

    // slot match
    // mult, result and prio slots are off at all ones, input slots at zero
    always_comb begin
        hit_id    = cpu.addr == map.id;
        hit_mult1 = cpu.addr == map.mult1 && map.mult1 != cpu_bus_pkg::ADDR_NONE;
        hit_mult2 = cpu.addr == map.mult2 && map.mult2 != cpu_bus_pkg::ADDR_NONE;
        hit_rslt0 = cpu.addr == map.rslt0 && map.rslt0 != cpu_bus_pkg::ADDR_NONE;
        hit_rslt1 = cpu.addr == map.rslt1 && map.rslt1 != cpu_bus_pkg::ADDR_NONE;
        hit_layer = cpu.addr == map.layer;
        hit_prio0 = cpu.addr == map.prio0 && map.prio0 != cpu_bus_pkg::ADDR_NONE;
        hit_prio1 = cpu.addr == map.prio1 && map.prio1 != cpu_bus_pkg::ADDR_NONE;
        hit_prio2 = cpu.addr == map.prio2 && map.prio2 != cpu_bus_pkg::ADDR_NONE;
        hit_prio3 = cpu.addr == map.prio3 && map.prio3 != cpu_bus_pkg::ADDR_NONE;
        hit_pal   = cpu.addr == map.pal_page;
        hit_in2   = cpu.addr == map.in2 && map.in2 != '0;
        hit_in3   = cpu.addr == map.in3 && map.in3 != '0;
    end

    assign wr = cpu.ppu2_cs && (cpu.dsn != cpu_bus_pkg::DSN_NONE);

    // multiplier operands
    always_ff @(posedge clk) begin
        if (wr && hit_mult1) begin
            mult1 <= cpu.wdata;
        end
        if (wr && hit_mult2) begin
            mult2 <= cpu.wdata;
        end
    end

    // product pipeline, the first stage holds the raw product
    always_ff @(posedge clk) begin
        prod_pipe[0] <= mult1 * mult2;
        for (int i = 1; i < MULT_LATENCY; i++) begin
            prod_pipe[i] <= prod_pipe[i-1];
        end
    end

    assign rslt = prod_pipe[MULT_LATENCY-1];

    // input bytes, read straight from the pins
    always_comb begin
        in3 = {players.start[3], players.coin[3], players.joy4[5:0]};
        if (map.six_button) begin
            // extra punch and kick buttons of players 1 and 2
            in2 = {1'b1, players.joy2[9:7], 1'b1, players.joy1[9:7]};
        end else begin
            in2 = {players.start[2], players.coin[2], players.joy3[5:0]};
        end
    end

    // read mux, first matching slot wins
    always_comb begin
        rd_val = 16'hffff;
        if (cpu.addr != cpu_bus_pkg::ADDR_NONE) begin
            if (hit_id) begin
                rd_val = {4'd0, map.cpsb_id[7:4], 4'd0, map.cpsb_id[3:0]};
            end else if (hit_mult1) begin
                rd_val = mult1;
            end else if (hit_mult2) begin
                rd_val = mult2;
            end else if (hit_rslt0) begin
                rd_val = rslt[15:0];
            end else if (hit_rslt1) begin
                rd_val = rslt[31:16];
            end else if (hit_layer) begin
                rd_val = mix.layer_ctrl;
            end else if (hit_prio0) begin
                rd_val = mix.prio0;
            end else if (hit_prio1) begin
                rd_val = mix.prio1;
            end else if (hit_prio2) begin
                rd_val = mix.prio2;
            end else if (hit_prio3) begin
                rd_val = mix.prio3;
            end else if (hit_pal) begin
                rd_val = {10'd0, mix.pal_page_en};
            end else if (hit_in2) begin
                rd_val = {in2, in2};
            end else if (hit_in3) begin
                rd_val = {in3, in3};
            end
        end
    end

    // mixer registers and registered read data
    always_ff @(posedge clk, posedge reg_rst) begin
        if (reg_rst) begin
            mix.layer_ctrl  <= video_regs_pkg::LAYER_CTRL_RST;
            mix.prio0       <= '0;
            mix.prio1       <= '0;
            mix.prio2       <= '0;
            mix.prio3       <= '0;
            mix.pal_page_en <= video_regs_pkg::PAL_PAGE_RST;
            mmr_dout        <= 16'hffff;
        end else begin
            if (cpu.ppu2_cs) begin
                mmr_dout <= rd_val;
            end
            if (wr) begin
                if (hit_layer) mix.layer_ctrl  <= cpu.wdata;
                if (hit_prio0) mix.prio0       <= cpu.wdata;
                if (hit_prio1) mix.prio1       <= cpu.wdata;
                if (hit_prio2) mix.prio2       <= cpu.wdata;
                if (hit_prio3) mix.prio3       <= cpu.wdata;
                if (hit_pal)   mix.pal_page_en <= cpu.wdata[5:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/video_mmr_top.sv ====
// register block of the video chip pair, fixed bank on ppu1_cs, programmable on ppu2_cs
// map is undefined until all 24 configuration bytes have been sent
`timescale 1ns/1ps
`default_nettype none

module video_mmr_top #(
    // multiplier register stages, 1 or 2
    parameter int MULT_LATENCY = 1
) (
    input  wire logic                       clk,
    input  wire logic                       reg_rst,
    input  wire logic                       pxl_cen,
    input  cpu_bus_pkg::cpu_req_t           cpu,
    input  wire logic                       cfg_we,
    input  wire logic [7:0]                 cfg_data,
    input  video_regs_pkg::player_in_t      players,
    output logic [15:0]                     mmr_dout,
    output video_regs_pkg::scroll_regs_t    scroll,
    output video_regs_pkg::base_regs_t      bases,
    output video_regs_pkg::mix_regs_t       mix,
    output video_regs_pkg::cfg_map_t        map,
    output logic                            pal_copy,
    output logic                            obj_dma_ok
);

    // configuration string, also exported for the mapper and layer masks
    cfg_map_loader u_loader (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .map      (map)
    );

    // scroll, base pointers and copy strobes
    fixed_reg_bank u_fixed (
        .clk        (clk),
        .reg_rst    (reg_rst),
        .pxl_cen    (pxl_cen),
        .cpu        (cpu),
        .scroll     (scroll),
        .bases      (bases),
        .pal_copy   (pal_copy),
        .obj_dma_ok (obj_dma_ok)
    );

    // id, multiplier, mixer and player inputs
    prog_reg_bank #(
        .MULT_LATENCY (MULT_LATENCY)
    ) u_prog (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .cpu      (cpu),
        .map      (map),
        .players  (players),
        .mix      (mix),
        .mmr_dout (mmr_dout)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
// free-running testbench clock, starts low
// period in ns, even values only
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== testbench/video_mmr_props.sv ====
// bus and strobe rules, bound into both register banks
// ports a bank lacks are tied to constants at the bind
`timescale 1ns/1ps
`default_nettype none

module video_mmr_props #(
    // 1 for the fixed bank strobe rules, 0 for the programmable bank read rule
    parameter bit FIXED_BANK = 1'b1
) (
    input wire logic                   clk,
    input wire logic                   reg_rst,
    input wire logic                   pxl_cen,
    input cpu_bus_pkg::cpu_req_t       cpu,
    input wire logic                   pal_copy,
    input wire logic                   obj_dma_ok,
    input wire logic [15:0]            mmr_dout
);

    generate
        if (FIXED_BANK) begin : g_fixed
            // palette copy only moves on an idle pixel clock
            a_copy_on_idle_pxl: assert property (@(posedge clk) disable iff (reg_rst)
                $rose(pal_copy) |-> $past(pxl_cen && !cpu.ppu1_cs))
                else $error("pal_copy rose without an idle pixel clock before it");

            // first clock out of reset
            a_quiet_after_reset: assert property (@(posedge clk)
                $past(reg_rst) && !reg_rst |-> !pal_copy && !obj_dma_ok)
                else $error("strobe high in the cycle after reset");
        end else begin : g_prog
            // the all-ones word never maps to a register
            a_none_reads_ffff: assert property (@(posedge clk) disable iff (reg_rst)
                cpu.ppu2_cs && cpu.addr == cpu_bus_pkg::ADDR_NONE |=> mmr_dout == 16'hffff)
                else $error("read of the all-ones address did not return ffff");
        end
    endgenerate

endmodule

bind fixed_reg_bank video_mmr_props #(.FIXED_BANK(1'b1)) u_props_fixed (
    .clk(clk), .reg_rst(reg_rst), .pxl_cen(pxl_cen), .cpu(cpu),
    .pal_copy(pal_copy), .obj_dma_ok(obj_dma_ok), .mmr_dout(16'hffff)
);

bind prog_reg_bank video_mmr_props #(.FIXED_BANK(1'b0)) u_props_prog (
    .clk(clk), .reg_rst(reg_rst), .pxl_cen(1'b0), .cpu(cpu),
    .pal_copy(1'b0), .obj_dma_ok(1'b0), .mmr_dout(mmr_dout)
);

`default_nettype wire

// ==== testbench/tb_video_mmr.sv ====
// table-driven test of the register block against a cycle model kept here
// inputs change on the falling edge, outputs are compared on the next falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_video_mmr;

    localparam int ML = 2;

    typedef enum logic [2:0] {OP_CFG, OP_FWR, OP_PWR, OP_RD, OP_IDLE} op_t;

    // one table row, exp is checked only with has_exp set
    typedef struct packed {
        op_t         op;
        logic [1:0]  dsn;
        logic [4:0]  addr;
        logic [15:0] data;
        logic [15:0] exp;
        logic        has_exp;
    } entry_t;

    logic clk, reg_rst, pxl_cen, cfg_we, pal_copy, obj_dma_ok;
    logic [7:0] cfg_data;
    logic [15:0] mmr_dout;
    cpu_bus_pkg::cpu_req_t cpu;
    video_regs_pkg::player_in_t players;
    video_regs_pkg::scroll_regs_t scroll;
    video_regs_pkg::base_regs_t bases;
    video_regs_pkg::mix_regs_t mix;
    video_regs_pkg::cfg_map_t map;

    entry_t tbl [0:127];
    int n_entries = 0;
    int n_checks = 0;
    int n_errors = 0;
    logic [15:0] rnd_state = 16'd88;
    logic [7:0] cfg_a [0:23];

    // model state
    logic [7:0]  cb [0:23];
    int          cfg_count = 0;
    logic        m_last_we = 1'b0;
    logic [15:0] fw [0:17];
    logic [15:0] m_m1 = '0, m_m2 = '0, m_dout;
    logic [31:0] m_pipe [0:ML-1];
    video_regs_pkg::mix_regs_t m_mix;
    logic pend_c, pend_d, m_pc, m_od;

    tb_clkgen #(.PERIOD(40)) u_clk (.clk(clk));

    video_mmr_top #(.MULT_LATENCY(ML)) u_dut (
        .clk(clk), .reg_rst(reg_rst), .pxl_cen(pxl_cen), .cpu(cpu),
        .cfg_we(cfg_we), .cfg_data(cfg_data), .players(players),
        .mmr_dout(mmr_dout), .scroll(scroll), .bases(bases), .mix(mix), .map(map),
        .pal_copy(pal_copy), .obj_dma_ok(obj_dma_ok)
    );

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic next_rand_bit();
        logic fb;
        fb = rnd_state[15] ^ rnd_state[13] ^ rnd_state[12] ^ rnd_state[10];
        rnd_state = {rnd_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [4:0] slot(int idx);
        return cb[idx][5:1];
    endfunction

    // mult, result and prio slots are off at all ones
    function automatic logic hit_ones(int idx, logic [4:0] a);
        return slot(idx) == a && slot(idx) != 5'h1f;
    endfunction

    // input slots are off at zero
    function automatic logic hit_zero(int idx, logic [4:0] a);
        return slot(idx) == a && slot(idx) != 5'h00;
    endfunction

    function automatic logic [15:0] read_model(logic [4:0] a);
        logic [7:0] b;
        if (a == 5'h1f) return 16'hffff;
        if (slot(0) == a) return {4'd0, cb[1][7:4], 4'd0, cb[1][3:0]};
        if (hit_ones(2, a)) return m_m1;
        if (hit_ones(3, a)) return m_m2;
        if (hit_ones(4, a)) return m_pipe[ML-1][15:0];
        if (hit_ones(5, a)) return m_pipe[ML-1][31:16];
        if (slot(6) == a) return m_mix.layer_ctrl;
        if (hit_ones(7, a)) return m_mix.prio0;
        if (hit_ones(8, a)) return m_mix.prio1;
        if (hit_ones(9, a)) return m_mix.prio2;
        if (hit_ones(10, a)) return m_mix.prio3;
        if (slot(13) == a) return {10'd0, m_mix.pal_page_en};
        if (hit_zero(11, a)) begin
            // six-button flag is bit 3 of the flag byte
            if (cb[23][3]) b = {1'b1, players.joy2[9:7], 1'b1, players.joy1[9:7]};
            else b = {players.start[2], players.coin[2], players.joy3[5:0]};
            return {b, b};
        end
        if (hit_zero(12, a)) begin
            b = {players.start[3], players.coin[3], players.joy4[5:0]};
            return {b, b};
        end
        return 16'hffff;
    endfunction

    // one rising edge of the model
    task automatic model_clock(cpu_bus_pkg::cpu_req_t req, logic pxl, logic we, logic [7:0] d);
        logic [15:0] rd;
        rd = read_model(req.addr);
        for (int i = ML - 1; i > 0; i--) m_pipe[i] = m_pipe[i-1];
        m_pipe[0] = {16'd0, m_m1} * {16'd0, m_m2};
        if (pxl && !req.ppu1_cs) begin
            m_pc = pend_c;
            m_od = pend_d;
            pend_c = 1'b0;
            pend_d = 1'b0;
        end
        if (req.ppu1_cs && req.dsn == 2'b00 && req.addr <= 5'd17) begin
            fw[req.addr] = req.wdata;
            if (req.addr == 5'd0) pend_d = 1'b1;
            if (req.addr == 5'd5) pend_c = 1'b1;
        end
        if (req.ppu2_cs) m_dout = rd;
        if (req.ppu2_cs && req.dsn != 2'b11) begin
            if (hit_ones(2, req.addr)) m_m1 = req.wdata;
            if (hit_ones(3, req.addr)) m_m2 = req.wdata;
            if (slot(6) == req.addr) m_mix.layer_ctrl = req.wdata;
            if (hit_ones(7, req.addr)) m_mix.prio0 = req.wdata;
            if (hit_ones(8, req.addr)) m_mix.prio1 = req.wdata;
            if (hit_ones(9, req.addr)) m_mix.prio2 = req.wdata;
            if (hit_ones(10, req.addr)) m_mix.prio3 = req.wdata;
            if (slot(13) == req.addr) m_mix.pal_page_en = req.wdata[5:0];
        end
        if (we && !m_last_we) begin
            for (int i = 0; i < 23; i++) cb[i] = cb[i+1];
            cb[23] = d;
            cfg_count++;
        end
        m_last_we = we;
    endtask

    task automatic check_val(string name, logic [159:0] got, logic [159:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("ERR %s exp=%h got=%h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_outputs();
        video_regs_pkg::scroll_regs_t s;
        video_regs_pkg::base_regs_t b;
        s = {fw[6], fw[8], fw[10], fw[7], fw[9], fw[11], fw[12], fw[14], fw[13], fw[15]};
        b = {fw[1], fw[2], fw[3], fw[0], fw[4], fw[16], fw[5], fw[17]};
        check_val("mmr_dout", 160'(mmr_dout), 160'(m_dout));
        check_val("pal_copy", 160'(pal_copy), 160'(m_pc));
        check_val("obj_dma_ok", 160'(obj_dma_ok), 160'(m_od));
        check_val("mix", 160'(mix), 160'(m_mix));
        check_val("scroll", 160'(scroll), 160'(s));
        check_val("bases", 160'(bases), 160'(b));
        if (cfg_count >= 24) begin
            check_val("map.slots", 160'({map.id, map.mult1, map.mult2, map.rslt0, map.rslt1,
                map.layer, map.prio0, map.prio1, map.prio2, map.prio3, map.in2, map.in3,
                map.pal_page}), 160'({slot(0), slot(2), slot(3), slot(4), slot(5), slot(6),
                slot(7), slot(8), slot(9), slot(10), slot(11), slot(12), slot(13)}));
            check_val("map.cpsb_id", 160'(map.cpsb_id), 160'(cb[1]));
            check_val("map.layer_masks", 160'({map.layer_mask0, map.layer_mask1,
                map.layer_mask2, map.layer_mask3}), 160'({cb[14], cb[15], cb[16], cb[17]}));
            check_val("map.game", 160'(map.game), 160'(cb[18][5:0]));
            check_val("map.bank_offset", 160'(map.bank_offset), 160'({cb[20], cb[19]}));
            check_val("map.bank_mask", 160'(map.bank_mask), 160'({cb[22], cb[21]}));
            check_val("map.flags", 160'({map.cpu_speed, map.six_button, map.charger,
                map.kabuki_en}), 160'({cb[23][0], cb[23][3], cb[23][4], cb[23][5]}));
        end
    endtask

    // drive one clock from a falling edge and compare at the next one
    task automatic run_cycle(cpu_bus_pkg::cpu_req_t req, logic pxl, logic we, logic [7:0] d);
        logic [47:0] v;
        for (int i = 0; i < 48; i++) v[i] = next_rand_bit();
        cpu = req;
        pxl_cen = pxl;
        cfg_we = we;
        cfg_data = d;
        players = v;
        @(posedge clk);
        model_clock(req, pxl, we, d);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic run_entry(entry_t e);
        cpu_bus_pkg::cpu_req_t req;
        req = '{ppu1_cs: 1'b0, ppu2_cs: 1'b0, addr: e.addr, dsn: e.dsn, wdata: e.data};
        case (e.op)
            OP_CFG: begin
                // low cycle after each byte so every byte gives an edge
                run_cycle(req, 1'b0, 1'b1, e.data[7:0]);
                run_cycle(req, 1'b0, 1'b0, 8'h00);
            end
            OP_FWR: begin
                // pixel enable high while the bus is busy, strobes must still wait
                req.ppu1_cs = 1'b1;
                run_cycle(req, 1'b1, 1'b0, 8'h00);
            end
            OP_PWR, OP_RD: begin
                req.ppu2_cs = 1'b1;
                run_cycle(req, 1'b0, 1'b0, 8'h00);
                if (e.op == OP_RD && e.has_exp) check_val("mmr_dout", 160'(mmr_dout), 160'(e.exp));
            end
            default: begin
                run_cycle(req, e.data[0], 1'b0, 8'h00);
                if (e.has_exp) check_val("strobes", 160'({obj_dma_ok, pal_copy}), 160'(e.exp[1:0]));
            end
        endcase
    endtask

    task automatic add(op_t op, logic [1:0] dsn, logic [4:0] a, logic [15:0] d,
                       logic [15:0] exp, logic has);
        tbl[n_entries] = '{op: op, dsn: dsn, addr: a, data: d, exp: exp, has_exp: has};
        n_entries++;
    endtask

    task automatic add_cfg();
        for (int i = 0; i < 24; i++) add(OP_CFG, 2'b11, 5'd0, {8'd0, cfg_a[i]}, 16'd0, 1'b0);
    endtask

    task automatic fill_table();
        // id 01, mult 02 03, results 04 05, layer 06, prio 07 08 off 0a
        // in2 0b, in3 off, pal page 0d, speed six-button charger kabuki flags on
        cfg_a = '{8'h02, 8'ha5, 8'h04, 8'h06, 8'h08, 8'h0a, 8'h0c, 8'h0e,
                  8'h10, 8'h3e, 8'h14, 8'h16, 8'h00, 8'h1a, 8'h11, 8'h22,
                  8'h44, 8'h88, 8'h2b, 8'h34, 8'h12, 8'hff, 8'h00, 8'h39};
        add(OP_RD, 2'b11, 5'h1f, 16'd0, 16'hffff, 1'b1);
        add(OP_IDLE, 2'b11, 5'd0, 16'd1, 16'd0, 1'b1);
        add_cfg();
        add(OP_RD, 2'b11, 5'h01, 16'd0, 16'h0a05, 1'b1);
        add(OP_RD, 2'b11, 5'h0b, 16'd0, 16'd0, 1'b0);
        add(OP_RD, 2'b11, 5'h0d, 16'd0, 16'h003f, 1'b1);
        add(OP_RD, 2'b11, 5'h06, 16'd0, 16'h1c80, 1'b1);
        // fixed bank, second write is partial
        add(OP_FWR, 2'b00, 5'h06, 16'h0123, 16'd0, 1'b0);
        add(OP_FWR, 2'b01, 5'h07, 16'h4567, 16'd0, 1'b0);
        add(OP_FWR, 2'b00, 5'h05, 16'h0a00, 16'd0, 1'b0);
        // busy bus with the copy pending
        add(OP_FWR, 2'b00, 5'h11, 16'hbeef, 16'd0, 1'b0);
        add(OP_IDLE, 2'b11, 5'd0, 16'd0, 16'd0, 1'b1);
        add(OP_IDLE, 2'b11, 5'd0, 16'd1, 16'd1, 1'b1);
        add(OP_IDLE, 2'b11, 5'd0, 16'd0, 16'd1, 1'b1);
        add(OP_IDLE, 2'b11, 5'd0, 16'd1, 16'd0, 1'b1);
        add(OP_FWR, 2'b00, 5'h00, 16'h1000, 16'd0, 1'b0);
        add(OP_IDLE, 2'b11, 5'd0, 16'd1, 16'd2, 1'b1);
        add(OP_IDLE, 2'b11, 5'd0, 16'd1, 16'd0, 1'b1);
        // multiplier, 1234 x abcd = 0c374fa4
        add(OP_PWR, 2'b00, 5'h02, 16'h1234, 16'd0, 1'b0);
        add(OP_PWR, 2'b10, 5'h03, 16'habcd, 16'd0, 1'b0);
        add(OP_RD, 2'b11, 5'h02, 16'd0, 16'h1234, 1'b1);
        add(OP_RD, 2'b11, 5'h03, 16'd0, 16'habcd, 1'b1);
        for (int i = 0; i < 3; i++) add(OP_IDLE, 2'b11, 5'd0, 16'd0, 16'd0, 1'b0);
        add(OP_RD, 2'b11, 5'h04, 16'd0, 16'h4fa4, 1'b1);
        add(OP_RD, 2'b11, 5'h05, 16'd0, 16'h0c37, 1'b1);
        // mixer and disabled slots
        add(OP_PWR, 2'b00, 5'h07, 16'h00f1, 16'd0, 1'b0);
        add(OP_RD, 2'b11, 5'h07, 16'd0, 16'h00f1, 1'b1);
        add(OP_PWR, 2'b00, 5'h1f, 16'h5555, 16'd0, 1'b0);
        add(OP_RD, 2'b11, 5'h1f, 16'd0, 16'hffff, 1'b1);
        add(OP_RD, 2'b11, 5'h00, 16'd0, 16'hffff, 1'b1);
        add(OP_PWR, 2'b00, 5'h0d, 16'h0015, 16'd0, 1'b0);
        add(OP_RD, 2'b11, 5'h0d, 16'd0, 16'h0015, 1'b1);
        add(OP_PWR, 2'b11, 5'h06, 16'h7777, 16'd0, 1'b0);
        add(OP_RD, 2'b11, 5'h06, 16'd0, 16'h1c80, 1'b1);
        // second map: mult2 off, in3 at 0c, all flags off
        cfg_a[3] = 8'h3e;
        cfg_a[12] = 8'h18;
        cfg_a[23] = 8'h00;
        add_cfg();
        add(OP_RD, 2'b11, 5'h0b, 16'd0, 16'd0, 1'b0);
        add(OP_RD, 2'b11, 5'h0c, 16'd0, 16'd0, 1'b0);
        add(OP_PWR, 2'b00, 5'h03, 16'h7777, 16'd0, 1'b0);
        // all-ones word must miss the disabled mult2 and prio2 slots
        add(OP_PWR, 2'b00, 5'h1f, 16'h7777, 16'd0, 1'b0);
        add(OP_RD, 2'b11, 5'h03, 16'd0, 16'hffff, 1'b1);
        add(OP_RD, 2'b11, 5'h02, 16'd0, 16'h1234, 1'b1);
        // product still from the old operands
        add(OP_RD, 2'b11, 5'h04, 16'd0, 16'h4fa4, 1'b1);
    endtask

    initial begin
        reg_rst = 1'b1;
        pxl_cen = 1'b0;
        cpu = '0;
        cfg_we = 1'b0;
        cfg_data = 8'h00;
        players = '0;
        for (int i = 0; i < 18; i++) fw[i] = '0;
        for (int i = 0; i < 24; i++) cb[i] = '0;
        for (int i = 0; i < ML; i++) m_pipe[i] = '0;
        m_mix = '{layer_ctrl: video_regs_pkg::LAYER_CTRL_RST, prio0: 16'd0, prio1: 16'd0,
                  prio2: 16'd0, prio3: 16'd0, pal_page_en: video_regs_pkg::PAL_PAGE_RST};
        m_dout = 16'hffff;
        {pend_c, pend_d, m_pc, m_od} = 4'b0000;
        fill_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reg_rst = 1'b0;
        check_outputs();
        for (int i = 0; i < n_entries; i++) run_entry(tbl[i]);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog, 20 clocks per table row
    initial begin
        wait (n_entries > 0);
        repeat (n_entries * 20) @(posedge clk);
        $display("timeout: the table did not finish within %0d clocks", n_entries * 20);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/cpu_bus_pkg.sv
rtl/video_regs_pkg.sv
rtl/cfg_map_loader.sv
rtl/fixed_reg_bank.sv
rtl/prog_reg_bank.sv
rtl/video_mmr_top.sv
testbench/tb_clkgen.sv
testbench/video_mmr_props.sv
testbench/tb_video_mmr.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the register block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_video_mmr -o sim_video_mmr
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_video_mmr)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
